// File: hw/rv_id_pkg.sv
package rv_id_pkg;

    // ========================================================================
    // widths
    // ========================================================================
    typedef logic [31:0] xlen_t;     // data and address word
    typedef logic [4:0]  reg_idx_t;  // register index

    localparam xlen_t RESET_PC = 32'h8000_0000;  // reset and flush target

    // ========================================================================
    // major opcodes
    // ========================================================================
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ========================================================================
    // control encodings
    // ========================================================================
    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B   // lui result is operand 2
    } alu_op_e;

    typedef enum logic [3:0] {
        DMEM_NONE, LB, LH, LW, LBU, LHU, SB, SH, SW
    } dmem_type_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4       // link address of jal and jalr
    } wb_src_e;

endpackage

// File: hw/id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
    input  rv_id_pkg::xlen_t       instruction_i,
    output rv_id_pkg::alu_op_e     alu_op_o,
    output logic                   op1_pc_o,   // operand 1 is the instruction pc
    output logic                   op2_imm_o,  // operand 2 is the immediate
    output rv_id_pkg::imm_type_e   imm_type_o,
    output logic                   is_branch_o,
    output logic                   is_jal_o,
    output logic                   is_jalr_o,
    output rv_id_pkg::dmem_type_e  dmem_type_o,
    output rv_id_pkg::wb_src_e     wb_src_o,
    output logic                   wb_en_o,
    output logic                   illegal_o
);
    import rv_id_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;       // funct7 selects sub / sra
    logic       bad;
    logic       wb_en;
    alu_op_e    arith_op;

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];
    assign alt    = (funct7 == 7'b0100000);

    // shared funct3 map of op and op-imm
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op_o    = ALU_ADD;  // address and target adds by default
        op1_pc_o    = 1'b0;
        op2_imm_o   = 1'b0;
        imm_type_o  = IMM_I;
        is_branch_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        dmem_type_o = DMEM_NONE;
        wb_src_o    = WB_ALU;
        wb_en       = 1'b0;
        bad         = 1'b0;

        case (opcode)
            OPC_LUI: begin
                alu_op_o   = ALU_PASS_B;
                op2_imm_o  = 1'b1;
                imm_type_o = IMM_U;
                wb_en      = 1'b1;
            end
            OPC_AUIPC: begin
                op1_pc_o   = 1'b1;
                op2_imm_o  = 1'b1;
                imm_type_o = IMM_U;
                wb_en      = 1'b1;
            end
            OPC_JAL: begin
                op1_pc_o   = 1'b1;
                op2_imm_o  = 1'b1;
                imm_type_o = IMM_J;
                is_jal_o   = 1'b1;
                wb_src_o   = WB_PC4;
                wb_en      = 1'b1;
            end
            OPC_JALR: begin
                op2_imm_o = 1'b1;
                is_jalr_o = 1'b1;
                wb_src_o  = WB_PC4;
                wb_en     = 1'b1;
                bad       = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                imm_type_o  = IMM_B;  // compare done in execute
                is_branch_o = 1'b1;
                bad         = (funct3 == 3'b010) || (funct3 == 3'b011);
            end
            OPC_LOAD: begin
                op2_imm_o = 1'b1;
                wb_src_o  = WB_MEM;
                wb_en     = 1'b1;
                case (funct3)
                    3'b000:  dmem_type_o = LB;
                    3'b001:  dmem_type_o = LH;
                    3'b010:  dmem_type_o = LW;
                    3'b100:  dmem_type_o = LBU;
                    3'b101:  dmem_type_o = LHU;
                    default: bad = 1'b1;
                endcase
            end
            OPC_STORE: begin
                op2_imm_o  = 1'b1;
                imm_type_o = IMM_S;
                case (funct3)
                    3'b000:  dmem_type_o = SB;
                    3'b001:  dmem_type_o = SH;
                    3'b010:  dmem_type_o = SW;
                    default: bad = 1'b1;
                endcase
            end
            OPC_OPIMM: begin
                alu_op_o  = arith_op;
                op2_imm_o = 1'b1;
                wb_en     = 1'b1;
                if (funct3 == 3'b001) begin
                    bad = (funct7 != 7'b0);           // slli
                end else if (funct3 == 3'b101) begin
                    bad = (funct7 != 7'b0) && !alt;   // srli / srai
                end
            end
            OPC_OP: begin
                alu_op_o = arith_op;
                wb_en    = 1'b1;
                bad      = (funct7 != 7'b0) &&
                           !(alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            default: bad = 1'b1;
        endcase

        // an illegal word must not touch memory or redirect
        if (bad) begin
            dmem_type_o = DMEM_NONE;
            is_branch_o = 1'b0;
            is_jal_o    = 1'b0;
            is_jalr_o   = 1'b0;
        end
    end

    assign wb_en_o   = wb_en & ~bad;
    assign illegal_o = bad;

endmodule

// File: hw/id_imm_gen.sv
`timescale 1ns/1ps

module id_imm_gen (
    input  rv_id_pkg::xlen_t      instruction_i,
    input  rv_id_pkg::imm_type_e  imm_type_i,
    output rv_id_pkg::xlen_t      imm_o
);
    import rv_id_pkg::*;

    xlen_t ins;
    logic  sgn;

    assign ins = instruction_i;
    assign sgn = instruction_i[31];  // sign bit of every format

    always_comb begin
        case (imm_type_i)
            IMM_I: begin
                imm_o = {{20{sgn}}, ins[31:20]};
            end
            IMM_S: begin
                imm_o = {{20{sgn}}, ins[31:25], ins[11:7]};
            end
            IMM_B: begin
                imm_o = {{19{sgn}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            IMM_U: begin
                imm_o = {ins[31:12], 12'b0};
            end
            IMM_J: begin
                imm_o = {{11{sgn}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

// File: hw/id_regfile.sv
`timescale 1ns/1ps

module id_regfile (
    input  logic                clk,
    input  logic                resetn,
    input  rv_id_pkg::reg_idx_t rs1_addr_i,
    input  rv_id_pkg::reg_idx_t rs2_addr_i,
    input  rv_id_pkg::reg_idx_t rd_addr_i,
    input  rv_id_pkg::xlen_t    rd_data_i,
    input  logic                rd_wen_i,
    output rv_id_pkg::xlen_t    rs1_data_o,
    output rv_id_pkg::xlen_t    rs2_data_o
);
    import rv_id_pkg::*;

    xlen_t regs [32];

    // x0 is never written so it reads as zero
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen_i && rd_addr_i != 5'd0) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // reads see the array only, a write shows up next cycle
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

// File: hw/id_branch_pred.sv
`timescale 1ns/1ps

module id_branch_pred (
    input  logic             is_branch_i,
    input  logic             is_jal_i,
    input  logic             is_jalr_i,
    input  logic             rs1_depended_i,  // rs1 still in flight
    input  rv_id_pkg::xlen_t pc_i,
    input  rv_id_pkg::xlen_t imm_i,
    input  rv_id_pkg::xlen_t rs1_data_i,
    output logic             pred_taken_o,
    output rv_id_pkg::xlen_t pred_pc_o
);
    import rv_id_pkg::*;

    xlen_t pc_plus4;
    xlen_t pc_rel;
    xlen_t jalr_sum;
    logic  br_taken;
    logic  jalr_taken;

    assign pc_plus4 = pc_i + 32'd4;
    assign pc_rel   = pc_i + imm_i;
    assign jalr_sum = rs1_data_i + imm_i;

    assign br_taken   = is_branch_i & imm_i[31];        // backward only
    assign jalr_taken = is_jalr_i & ~rs1_depended_i;    // stale rs1 is no target

    assign pred_taken_o = br_taken | is_jal_i | jalr_taken;

    always_comb begin
        if (jalr_taken) begin
            pred_pc_o = {jalr_sum[31:1], 1'b0};
        end else if (br_taken || is_jal_i) begin
            pred_pc_o = pc_rel;
        end else begin
            pred_pc_o = pc_plus4;  // fall through
        end
    end

endmodule

// File: hw/id_pc_redirect.sv
`timescale 1ns/1ps

module id_pc_redirect (
    input  logic             clk,
    input  logic             resetn,
    input  logic             enable_i,
    input  logic             flush_i,
    input  logic             redirect_exe_i,
    input  rv_id_pkg::xlen_t redirect_pc_exe_i,
    input  logic             pred_taken_i,
    input  rv_id_pkg::xlen_t pred_pc_i,
    output rv_id_pkg::xlen_t pc_instr_o,
    output logic             taken_o,
    output rv_id_pkg::xlen_t redirection_pc_o
);
    import rv_id_pkg::*;

    logic  resetn_dly;   // low in the first cycle after release
    logic  taken_q;      // redirect pending for pc_instr
    xlen_t target_q;
    xlen_t pc_instr;

    always_ff @(posedge clk) begin
        resetn_dly <= resetn;
    end

    // ========================================================================
    // redirection toward fetch
    // ========================================================================
    assign taken_o = ~resetn_dly | redirect_exe_i | (pred_taken_i & ~flush_i);

    always_comb begin
        if (!resetn_dly) begin
            redirection_pc_o = RESET_PC;
        end else if (redirect_exe_i) begin
            redirection_pc_o = redirect_pc_exe_i;
        end else begin
            redirection_pc_o = pred_pc_i;  // predictor, pc+4 when not taken
        end
    end

    // ========================================================================
    // instruction pc
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            taken_q  <= 1'b1;
            target_q <= RESET_PC;
        end else if (taken_o) begin
            taken_q  <= 1'b1;                // held until an enabled edge uses it
            target_q <= redirection_pc_o;
        end else if (enable_i) begin
            taken_q  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pc_instr <= RESET_PC;
        end else if (enable_i) begin
            pc_instr <= taken_q ? target_q : pc_instr + 32'd4;
        end
    end

    assign pc_instr_o = pc_instr;

endmodule

// File: hw/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   enable_i,        // stall when low
    input  logic                   flush_i,
    input  rv_id_pkg::xlen_t       instruction_i,
    input  logic                   redirect_exe_i,
    input  rv_id_pkg::xlen_t       redirect_pc_exe_i,
    input  logic                   wb_en_i,
    input  rv_id_pkg::reg_idx_t    wb_rd_i,
    input  rv_id_pkg::xlen_t       wb_data_i,
    input  logic                   rs1_depended_i,
    output logic                   taken_o,
    output rv_id_pkg::xlen_t       redirection_pc_o,
    output rv_id_pkg::alu_op_e     alu_op_o,
    output rv_id_pkg::xlen_t       rs1_val_o,
    output rv_id_pkg::xlen_t       rs2_val_o,
    output rv_id_pkg::xlen_t       rs2_reg_o,       // store data
    output rv_id_pkg::xlen_t       imm_o,
    output rv_id_pkg::xlen_t       pc_next_o,
    output rv_id_pkg::xlen_t       prediction_pc_o,
    output rv_id_pkg::reg_idx_t    rd_o,
    output logic                   reg_write_en_o,
    output rv_id_pkg::wb_src_e     wb_src_o,
    output rv_id_pkg::dmem_type_e  dmem_type_o,
    output logic                   is_branch_o,
    output logic                   is_jalr_o,
    output logic                   sbp_taken_o,
    output logic                   illegal_o
);
    import rv_id_pkg::*;

    // ========================================================================
    // decode side signals
    // ========================================================================
    alu_op_e    dec_alu_op;
    logic       dec_op1_pc;
    logic       dec_op2_imm;
    imm_type_e  dec_imm_type;
    logic       dec_branch;
    logic       dec_jal;
    logic       dec_jalr;
    dmem_type_e dec_dmem;
    wb_src_e    dec_wb_src;
    logic       dec_wb_en;
    logic       dec_illegal;
    xlen_t      imm;
    xlen_t      rs1_data;
    xlen_t      rs2_data;
    xlen_t      pc_instr;
    logic       pred_taken;
    xlen_t      pred_pc;

    id_decoder i_decoder (
        .instruction_i (instruction_i),
        .alu_op_o      (dec_alu_op),
        .op1_pc_o      (dec_op1_pc),
        .op2_imm_o     (dec_op2_imm),
        .imm_type_o    (dec_imm_type),
        .is_branch_o   (dec_branch),
        .is_jal_o      (dec_jal),
        .is_jalr_o     (dec_jalr),
        .dmem_type_o   (dec_dmem),
        .wb_src_o      (dec_wb_src),
        .wb_en_o       (dec_wb_en),
        .illegal_o     (dec_illegal)
    );

    id_imm_gen i_imm_gen (
        .instruction_i (instruction_i),
        .imm_type_i    (dec_imm_type),
        .imm_o         (imm)
    );

    id_regfile i_regfile (
        .clk        (clk),
        .resetn     (resetn),
        .rs1_addr_i (instruction_i[19:15]),
        .rs2_addr_i (instruction_i[24:20]),
        .rd_addr_i  (wb_rd_i),
        .rd_data_i  (wb_data_i),
        .rd_wen_i   (wb_en_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    id_branch_pred i_branch_pred (
        .is_branch_i    (dec_branch),
        .is_jal_i       (dec_jal),
        .is_jalr_i      (dec_jalr),
        .rs1_depended_i (rs1_depended_i),
        .pc_i           (pc_instr),
        .imm_i          (imm),
        .rs1_data_i     (rs1_data),
        .pred_taken_o   (pred_taken),
        .pred_pc_o      (pred_pc)
    );

    id_pc_redirect i_pc_redirect (
        .clk               (clk),
        .resetn            (resetn),
        .enable_i          (enable_i),
        .flush_i           (flush_i),
        .redirect_exe_i    (redirect_exe_i),
        .redirect_pc_exe_i (redirect_pc_exe_i),
        .pred_taken_i      (pred_taken),
        .pred_pc_i         (pred_pc),
        .pc_instr_o        (pc_instr),
        .taken_o           (taken_o),
        .redirection_pc_o  (redirection_pc_o)
    );

    // ========================================================================
    // pipeline register toward execute
    // ========================================================================
    always_ff @(posedge clk) begin
        if (!resetn || flush_i) begin
            reg_write_en_o  <= 1'b0;
            is_branch_o     <= 1'b0;
            is_jalr_o       <= 1'b0;
            sbp_taken_o     <= 1'b0;
            illegal_o       <= 1'b0;
            dmem_type_o     <= DMEM_NONE;
            prediction_pc_o <= RESET_PC;
        end else if (enable_i) begin
            reg_write_en_o  <= dec_wb_en & ~dec_illegal;
            is_branch_o     <= dec_branch;
            is_jalr_o       <= dec_jalr;
            sbp_taken_o     <= pred_taken;
            illegal_o       <= dec_illegal;
            dmem_type_o     <= dec_dmem;
            prediction_pc_o <= pred_pc;
        end
    end

    // payload follows the stall only
    always_ff @(posedge clk) begin
        if (enable_i) begin
            alu_op_o  <= dec_alu_op;
            rs1_val_o <= dec_op1_pc ? pc_instr : rs1_data;   // auipc, jal
            rs2_val_o <= dec_op2_imm ? imm : rs2_data;
            rs2_reg_o <= rs2_data;
            imm_o     <= imm;
            pc_next_o <= pc_instr + 32'd4;
            rd_o      <= instruction_i[11:7];
            wb_src_o  <= dec_wb_src;
        end
    end

endmodule

// File: testbench/tb_id_tests.svh
`ifndef TB_ID_TESTS_SVH
`define TB_ID_TESTS_SVH

localparam xlen_t X5_VAL       = 32'h1234_5678;
localparam xlen_t X6_VAL       = 32'h0F0F_0F0F;
localparam xlen_t ILLEGAL_WORD = 32'h0000_0F7F;  // opcode 7'h7f is unused

// ============================================================================
// instruction words built from the RV32I formats
// ============================================================================
function automatic xlen_t op_word(input logic [6:0] f7, input reg_idx_t rs2,
                                  input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic xlen_t imm_word(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic xlen_t store_word(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic xlen_t branch_word(input logic [12:0] imm, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic xlen_t upper_word(input logic [19:0] imm, input reg_idx_t rd,
                                     input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic xlen_t jump_word(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

task automatic reset_redirect_test();
    xlen_t first_pc;
    @(negedge clk);
    check_value("taken_o", 32'(taken_o), 32'd1);
    expect_target(RESET_PC);
    cycle_taken = 1'b1;
    check_value("reg_write_en_o", 32'(reg_write_en_o), 32'd0);
    check_value("is_branch_o", 32'(is_branch_o), 32'd0);
    check_value("is_jalr_o", 32'(is_jalr_o), 32'd0);
    check_value("sbp_taken_o", 32'(sbp_taken_o), 32'd0);
    check_value("illegal_o", 32'(illegal_o), 32'd0);
    check_value("dmem_type_o", 32'(dmem_type_o), 32'(DMEM_NONE));
    check_value("prediction_pc_o", prediction_pc_o, RESET_PC);
    drive_cycle(NOP, 1'b1, 1'b0);
    first_pc = pc_model;
    drive_cycle(NOP, 1'b1, 1'b0);
    check_value("pc_next_o", pc_next_o, first_pc + 32'd4);
endtask

task automatic regfile_read_test();
    nx_wb_en   = 1'b1;
    nx_wb_rd   = 5'd5;
    nx_wb_data = X5_VAL;
    drive_cycle(NOP, 1'b1, 1'b0);
    nx_wb_rd   = 5'd6;
    nx_wb_data = X6_VAL;
    drive_cycle(NOP, 1'b1, 1'b0);
    nx_wb_rd   = 5'd0;
    nx_wb_data = 32'hDEAD_BEEF;  // must be dropped
    drive_cycle(NOP, 1'b1, 1'b0);
    nx_wb_en   = 1'b0;
    drive_cycle(op_word(7'h00, 5'd6, 5'd5, 3'b000, 5'd7), 1'b1, 1'b0);   // add x7
    drive_cycle(op_word(7'h20, 5'd6, 5'd5, 3'b000, 5'd8), 1'b1, 1'b0);   // sub x8
    check_value("rs1_val_o", rs1_val_o, X5_VAL);
    check_value("rs2_val_o", rs2_val_o, X6_VAL);
    check_value("alu_op_o", 32'(alu_op_o), 32'(ALU_ADD));
    check_value("rd_o", 32'(rd_o), 32'd7);
    check_value("reg_write_en_o", 32'(reg_write_en_o), 32'd1);
    check_value("wb_src_o", 32'(wb_src_o), 32'(WB_ALU));
    drive_cycle(op_word(7'h00, 5'd5, 5'd0, 3'b000, 5'd9), 1'b1, 1'b0);   // add x9, x0, x5
    check_value("alu_op_o", 32'(alu_op_o), 32'(ALU_SUB));
    check_value("rd_o", 32'(rd_o), 32'd8);
    check_value("rs2_val_o", rs2_val_o, X6_VAL);
    drive_cycle(NOP, 1'b1, 1'b0);
    check_value("rs1_val_o", rs1_val_o, 32'h0);   // x0 stays zero
    check_value("rs2_val_o", rs2_val_o, X5_VAL);
endtask

task automatic immediate_test();
    xlen_t auipc_pc;
    drive_cycle(imm_word(12'hFF0, 5'd5, 3'b000, 5'd10, OPC_OPIMM), 1'b1, 1'b0);
    drive_cycle(store_word(12'hFF8, 5'd6, 5'd5, 3'b010), 1'b1, 1'b0);
    check_value("imm_o", imm_o, 32'hFFFF_FFF0);
    check_value("rs1_val_o", rs1_val_o, X5_VAL);
    check_value("rs2_val_o", rs2_val_o, 32'hFFFF_FFF0);
    check_value("rd_o", 32'(rd_o), 32'd10);
    check_value("dmem_type_o", 32'(dmem_type_o), 32'(DMEM_NONE));
    drive_cycle(upper_word(20'hABCDE, 5'd11, OPC_LUI), 1'b1, 1'b0);
    check_value("imm_o", imm_o, 32'hFFFF_FFF8);
    check_value("dmem_type_o", 32'(dmem_type_o), 32'(SW));
    check_value("rs2_reg_o", rs2_reg_o, X6_VAL);
    check_value("reg_write_en_o", 32'(reg_write_en_o), 32'd0);
    drive_cycle(upper_word(20'h00001, 5'd12, OPC_AUIPC), 1'b1, 1'b0);
    auipc_pc = pc_model;
    check_value("imm_o", imm_o, 32'hABCD_E000);
    check_value("rs2_val_o", rs2_val_o, 32'hABCD_E000);
    check_value("alu_op_o", 32'(alu_op_o), 32'(ALU_PASS_B));
    drive_cycle(NOP, 1'b1, 1'b0);
    check_value("rs1_val_o", rs1_val_o, auipc_pc);
    check_value("imm_o", imm_o, 32'h0000_1000);
endtask

task automatic prediction_test();
    xlen_t bpc;
    xlen_t fpc;
    xlen_t jpc;
    xlen_t jalr_tgt;
    drive_cycle(branch_word(13'h1FF8, 5'd0, 5'd0, 3'b000), 1'b1, 1'b1);  // beq -8
    bpc = pc_model;
    expect_target(bpc - 32'd8);
    drive_cycle(NOP, 1'b1, 1'b0);  // slot before the target arrives
    check_value("is_branch_o", 32'(is_branch_o), 32'd1);
    check_value("sbp_taken_o", 32'(sbp_taken_o), 32'd1);
    check_value("prediction_pc_o", prediction_pc_o, bpc - 32'd8);
    drive_cycle(NOP, 1'b1, 1'b0);
    drive_cycle(branch_word(13'h0010, 5'd5, 5'd0, 3'b001), 1'b1, 1'b0);  // bne +16
    fpc = pc_model;
    check_value("pc_next_o", pc_next_o, bpc - 32'd4);
    drive_cycle(jump_word(21'h000100, 5'd1), 1'b1, 1'b1);
    jpc = pc_model;
    expect_target(jpc + 32'h100);
    check_value("sbp_taken_o", 32'(sbp_taken_o), 32'd0);
    check_value("prediction_pc_o", prediction_pc_o, fpc + 32'd4);
    drive_cycle(NOP, 1'b1, 1'b0);
    check_value("sbp_taken_o", 32'(sbp_taken_o), 32'd1);
    check_value("wb_src_o", 32'(wb_src_o), 32'(WB_PC4));
    check_value("rs1_val_o", rs1_val_o, jpc);
    nx_dep = 1'b1;
    drive_cycle(imm_word(12'h005, 5'd5, 3'b000, 5'd1, OPC_JALR), 1'b1, 1'b0);
    nx_dep = 1'b0;
    jalr_tgt = (X5_VAL + 32'd5) & ~32'h1;
    drive_cycle(imm_word(12'h005, 5'd5, 3'b000, 5'd1, OPC_JALR), 1'b1, 1'b1);
    expect_target(jalr_tgt);
    check_value("is_jalr_o", 32'(is_jalr_o), 32'd1);
    check_value("sbp_taken_o", 32'(sbp_taken_o), 32'd0);
    drive_cycle(NOP, 1'b1, 1'b0);
    check_value("sbp_taken_o", 32'(sbp_taken_o), 32'd1);
    check_value("prediction_pc_o", prediction_pc_o, jalr_tgt);
endtask

task automatic redirect_flush_test();
    nx_redir    = 1'b1;
    nx_redir_pc = 32'h8000_1000;
    drive_cycle(jump_word(21'h000100, 5'd1), 1'b1, 1'b1);
    expect_target(32'h8000_1000);  // execute wins over the jal
    nx_redir = 1'b0;
    drive_cycle(store_word(12'h004, 5'd6, 5'd5, 3'b010), 1'b1, 1'b0);
    nx_flush = 1'b1;
    drive_cycle(jump_word(21'h000100, 5'd1), 1'b1, 1'b0);  // flush masks the jal
    check_value("dmem_type_o", 32'(dmem_type_o), 32'(SW));
    nx_flush = 1'b0;
    drive_cycle(NOP, 1'b1, 1'b0);
    check_value("reg_write_en_o", 32'(reg_write_en_o), 32'd0);
    check_value("sbp_taken_o", 32'(sbp_taken_o), 32'd0);
    check_value("is_branch_o", 32'(is_branch_o), 32'd0);
    check_value("is_jalr_o", 32'(is_jalr_o), 32'd0);
    check_value("dmem_type_o", 32'(dmem_type_o), 32'(DMEM_NONE));
    check_value("prediction_pc_o", prediction_pc_o, RESET_PC);
endtask

task automatic stall_illegal_test();
    xlen_t spc;
    xlen_t lui;
    lui = upper_word(20'h00042, 5'd14, OPC_LUI);
    drive_cycle(imm_word(12'h007, 5'd5, 3'b000, 5'd13, OPC_OPIMM), 1'b1, 1'b0);
    spc = pc_model;
    for (int i = 0; i < 4; i++) begin
        drive_cycle(lui, 1'b0, 1'b0);   // first edge takes the addi, then hold
        check_value("imm_o", imm_o, 32'h0000_0007);
        check_value("rd_o", 32'(rd_o), 32'd13);
        check_value("rs1_val_o", rs1_val_o, X5_VAL);
        check_value("pc_next_o", pc_next_o, spc + 32'd4);
        check_value("reg_write_en_o", 32'(reg_write_en_o), 32'd1);
    end
    drive_cycle(lui, 1'b1, 1'b0);
    drive_cycle(ILLEGAL_WORD, 1'b1, 1'b0);
    check_value("alu_op_o", 32'(alu_op_o), 32'(ALU_PASS_B));
    check_value("pc_next_o", pc_next_o, spc + 32'd8);
    // op with funct7 of the m extension, which this stage does not decode
    drive_cycle(op_word(7'h01, 5'd6, 5'd5, 3'b000, 5'd15), 1'b1, 1'b0);
    check_value("illegal_o", 32'(illegal_o), 32'd1);
    check_value("reg_write_en_o", 32'(reg_write_en_o), 32'd0);
    check_value("dmem_type_o", 32'(dmem_type_o), 32'(DMEM_NONE));
    drive_cycle(NOP, 1'b1, 1'b0);
    check_value("illegal_o", 32'(illegal_o), 32'd1);
    check_value("reg_write_en_o", 32'(reg_write_en_o), 32'd0);
endtask

`endif

// File: testbench/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import rv_id_pkg::*;

    localparam int    CLK_PERIOD = 20;
    localparam int    MAX_CYCLES = 200;            // tests use about 60
    localparam xlen_t NOP        = 32'h0000_0013;  // addi x0, x0, 0

    logic       clk;
    logic       resetn;
    logic       enable_i;
    logic       flush_i;
    xlen_t      instruction_i;
    logic       redirect_exe_i;
    xlen_t      redirect_pc_exe_i;
    logic       wb_en_i;
    reg_idx_t   wb_rd_i;
    xlen_t      wb_data_i;
    logic       rs1_depended_i;
    logic       taken_o;
    xlen_t      redirection_pc_o;
    alu_op_e    alu_op_o;
    xlen_t      rs1_val_o;
    xlen_t      rs2_val_o;
    xlen_t      rs2_reg_o;
    xlen_t      imm_o;
    xlen_t      pc_next_o;
    xlen_t      prediction_pc_o;
    reg_idx_t   rd_o;
    logic       reg_write_en_o;
    wb_src_e    wb_src_o;
    dmem_type_e dmem_type_o;
    logic       is_branch_o;
    logic       is_jalr_o;
    logic       sbp_taken_o;
    logic       illegal_o;

    // side inputs applied together with the next instruction
    logic       nx_flush;
    logic       nx_redir;
    xlen_t      nx_redir_pc;
    logic       nx_wb_en;
    reg_idx_t   nx_wb_rd;
    xlen_t      nx_wb_data;
    logic       nx_dep;

    // model of the instruction pc
    xlen_t      pc_model;
    logic       pc_pending;     // redirect waiting for an enabled edge
    xlen_t      pc_target;
    logic       cycle_taken;    // expected redirect in the current cycle
    xlen_t      cycle_target;

    int         check_count;
    int         error_count;

    id_stage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input xlen_t actual, input xlen_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED: %s got 0x%08h expected 0x%08h at %0t",
                     name, actual, expected, $time);
        end
    endtask

    // ========================================================================
    // one clock of stimulus, taken_o checked mid cycle
    // ========================================================================
    task automatic drive_cycle(input xlen_t instr, input logic en, input logic exp_taken);
        @(posedge clk);
        if (enable_i) begin
            pc_model = pc_pending ? pc_target : pc_model + 32'd4;
        end
        if (cycle_taken) begin
            pc_pending = 1'b1;
            pc_target  = cycle_target;
        end else if (enable_i) begin
            pc_pending = 1'b0;
        end
        instruction_i     <= instr;
        enable_i          <= en;
        flush_i           <= nx_flush;
        redirect_exe_i    <= nx_redir;
        redirect_pc_exe_i <= nx_redir_pc;
        wb_en_i           <= nx_wb_en;
        wb_rd_i           <= nx_wb_rd;
        wb_data_i         <= nx_wb_data;
        rs1_depended_i    <= nx_dep;
        @(negedge clk);
        check_value("taken_o", 32'(taken_o), 32'(exp_taken));
        cycle_taken  = exp_taken;
        cycle_target = RESET_PC;
    endtask

    task automatic expect_target(input xlen_t target);
        check_value("redirection_pc_o", redirection_pc_o, target);
        cycle_target = target;
    endtask

    `include "tb_id_tests.svh"

    initial begin
        resetn            = 1'b0;
        enable_i          = 1'b1;
        flush_i           = 1'b0;
        instruction_i     = NOP;
        redirect_exe_i    = 1'b0;
        redirect_pc_exe_i = 32'h0;
        wb_en_i           = 1'b0;
        wb_rd_i           = 5'd0;
        wb_data_i         = 32'h0;
        rs1_depended_i    = 1'b0;
        nx_flush          = 1'b0;
        nx_redir          = 1'b0;
        nx_redir_pc       = 32'h0;
        nx_wb_en          = 1'b0;
        nx_wb_rd          = 5'd0;
        nx_wb_data        = 32'h0;
        nx_dep            = 1'b0;
        cycle_taken       = 1'b0;
        cycle_target      = RESET_PC;
        check_count       = 0;
        error_count       = 0;

        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        pc_model   = RESET_PC;
        pc_pending = 1'b1;      // reset loads the redirect to RESET_PC
        pc_target  = RESET_PC;

        reset_redirect_test();
        regfile_read_test();
        immediate_test();
        prediction_test();
        redirect_flush_test();
        stall_illegal_test();

        $display("tb_id_stage: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(MAX_CYCLES * CLK_PERIOD + 200);
        $display("watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: rv_id.f
+incdir+testbench
hw/rv_id_pkg.sv
hw/id_decoder.sv
hw/id_imm_gen.sv
hw/id_regfile.sv
hw/id_branch_pred.sv
hw/id_pc_redirect.sv
hw/id_stage.sv
testbench/tb_id_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the decode stage testbench with Verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -j 0 --top-module tb_id_stage -f rv_id.f -o sim_id_stage
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_id_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Verification passed$"; then
    exit 0
fi
exit 1
